// File: hdl/xcom_pkg.sv
// command level constants of the xcom front end, referenced by scope from the rtl and testbench
package xcom_pkg;

  ////////////////////////////////////////
  // sizes
  ////////////////////////////////////////

  // number of serial lanes
  // kept below the broadcast address
  localparam int N_CH = 2;
  // opcode width from either source
  localparam int OP_W = 5;
  // host control word, enable in bit 0
  localparam int PS_CTRL_W = OP_W + 1;
  // lane address width
  localparam int ADDR_W = 4;
  // payload word width
  localparam int DATA_W = 32;
  // width of the debug command counters
  localparam int CNT_W = 4;
  // op field sent on the wire
  // upper nibble holds the opcode, lower nibble the address
  localparam int OPF_W = 8;

  ////////////////////////////////////////
  // opcodes
  ////////////////////////////////////////

  // set means network command, clear means local command
  localparam int OP_NET_BIT = 4;

  // local commands
  localparam logic [OP_W-1:0] OP_LOC_WREG = 5'b0_0001;
  localparam logic [OP_W-1:0] OP_LOC_FLAG = 5'b0_0010;
  // network command
  localparam logic [OP_W-1:0] OP_NET_SEND = 5'b1_0001;

  // address that selects every lane
  localparam logic [ADDR_W-1:0] ADDR_BCAST = 4'hF;

endpackage

// File: hdl/xcom_link_pkg.sv
// serial frame format of the xcom lanes, referenced by scope from the lane serializer and testbench
package xcom_link_pkg;

  // clocks spent on each serial bit
  localparam int BIT_CLKS = 4;
  // start bit, 8 op bits, 32 data bits, msb first
  localparam int FRAME_BITS = 41;

  // line levels
  localparam logic LINE_IDLE = 1'b1;
  localparam logic START_BIT = 1'b0;

  // counter widths and terminal values
  localparam int TMR_W = $clog2(BIT_CLKS);
  localparam int BCNT_W = $clog2(FRAME_BITS);
  localparam logic [TMR_W-1:0] TMR_LAST = TMR_W'(BIT_CLKS - 1);
  localparam logic [BCNT_W-1:0] BCNT_LAST = BCNT_W'(FRAME_BITS - 1);

endpackage

// File: hdl/xcom_cmd.sv
// command entry of xcom, merges core and host commands into one held request for the executors
`timescale 1ns/1ps

module xcom_cmd (
  input  logic                                 i_clk,
  input  logic                                 i_rst_n,
  // sequencer core command
  input  logic                                 i_core_en,
  input  logic [xcom_pkg::OP_W-1:0]            i_core_op,
  input  logic [1:0][xcom_pkg::DATA_W-1:0]     i_core_data,
  // host command
  input  logic [xcom_pkg::PS_CTRL_W-1:0]       i_ps_ctrl,
  input  logic [1:0][xcom_pkg::DATA_W-1:0]     i_ps_data,
  // executor handshake
  input  logic                                 i_ack_loc,
  input  logic                                 i_ack_net,
  output logic                                 o_req_loc,
  output logic                                 o_req_net,
  output logic [xcom_pkg::OP_W-1:0]            o_op,
  output logic [xcom_pkg::ADDR_W-1:0]          o_addr,
  output logic [xcom_pkg::DATA_W-1:0]          o_data,
  output logic [xcom_pkg::CNT_W-1:0]           o_data_cntr
);

  logic                          s_en;
  logic [xcom_pkg::OP_W-1:0]     s_op;
  logic [xcom_pkg::ADDR_W-1:0]   s_addr;
  logic [xcom_pkg::DATA_W-1:0]   s_data;
  logic                          s_rise;
  logic                          s_busy;
  logic                          s_accept;
  logic                          en_q;
  logic                          valid_q;
  logic [xcom_pkg::OP_W-1:0]     stg_op;
  logic [xcom_pkg::ADDR_W-1:0]   stg_addr;
  logic [xcom_pkg::DATA_W-1:0]   stg_data;

  ////////////////////////////////////////
  // source merge
  ////////////////////////////////////////

  // idle source drives zeros so a plain or selects the active one
  assign s_en   = i_ps_ctrl[0] | i_core_en;
  assign s_op   = i_ps_ctrl[xcom_pkg::PS_CTRL_W-1:1] | i_core_op;
  assign s_addr = i_ps_data[0][xcom_pkg::ADDR_W-1:0] | i_core_data[0][xcom_pkg::ADDR_W-1:0];
  assign s_data = i_ps_data[1] | i_core_data[1];

  // rising edge of the merged enable
  assign s_rise = s_en & ~en_q;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      en_q    <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      en_q    <= s_en;
      valid_q <= s_rise;
    end
  end

  // capture the command with its edge
  always_ff @(posedge i_clk) begin
    if (s_rise) begin
      stg_op   <= s_op;
      stg_addr <= s_addr;
      stg_data <= s_data;
    end
  end

  ////////////////////////////////////////
  // request and acknowledge
  ////////////////////////////////////////

  // edges seen while a request is pending are lost
  assign s_busy   = o_req_loc | o_req_net;
  assign s_accept = valid_q & ~s_busy;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_req_loc   <= 1'b0;
      o_req_net   <= 1'b0;
      o_data_cntr <= '0;
    end else if (s_accept) begin
      // opcode bit 4 steers the request
      o_req_net   <= stg_op[xcom_pkg::OP_NET_BIT];
      o_req_loc   <= ~stg_op[xcom_pkg::OP_NET_BIT];
      o_data_cntr <= o_data_cntr + 1'b1;
    end else begin
      if (i_ack_loc) begin
        o_req_loc <= 1'b0;
      end
      if (i_ack_net) begin
        o_req_net <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (s_accept) begin
      o_op   <= stg_op;
      o_addr <= stg_addr;
      o_data <= stg_data;
    end
  end

  // executors only answer the request that is pending
  a_ack_pending : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (!i_ack_loc || o_req_loc) && (!i_ack_net || o_req_net));

endmodule

// File: hdl/xcom_loc_exec.sv
// local command executor, writes the on-board register file or flag and acknowledges xcom_cmd
`timescale 1ns/1ps

module xcom_loc_exec (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  input  logic                          i_req,
  input  logic [xcom_pkg::OP_W-1:0]     i_op,
  input  logic [xcom_pkg::ADDR_W-1:0]   i_addr,
  input  logic [xcom_pkg::DATA_W-1:0]   i_data,
  // sequencer read port
  input  logic [xcom_pkg::ADDR_W-1:0]   i_rd_addr,
  output logic                          o_ack,
  output logic                          o_flag,
  output logic [xcom_pkg::DATA_W-1:0]   o_rd_data
);

  logic [xcom_pkg::DATA_W-1:0] regs [2**xcom_pkg::ADDR_W];
  logic                        s_exec;

  // act once per request
  // the held request is masked while ack is out
  assign s_exec = i_req & ~o_ack;

  ////////////////////////////////////////
  // execute
  ////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_ack  <= 1'b0;
      o_flag <= 1'b0;
      for (int i = 0; i < 2**xcom_pkg::ADDR_W; i++) begin
        regs[i] <= '0;
      end
    end else begin
      o_ack <= s_exec;
      if (s_exec) begin
        case (i_op)
          xcom_pkg::OP_LOC_WREG: regs[i_addr] <= i_data;
          xcom_pkg::OP_LOC_FLAG: o_flag <= i_data[0];
          // unknown opcodes only get the ack
          default: ;
        endcase
      end
    end
  end

  // asynchronous read for the sequencer
  assign o_rd_data = regs[i_rd_addr];

  // a request still up after its ack would run a second time
  a_req_drop : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_ack |=> !i_req);

endmodule

// File: hdl/xcom_lane_tx.sv
// one serial lane, shifts a start bit, op field and data word out msb first after each start pulse
`timescale 1ns/1ps

module xcom_lane_tx (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  input  logic                          i_start,
  input  logic [xcom_pkg::OPF_W-1:0]    i_op,
  input  logic [xcom_pkg::DATA_W-1:0]   i_data,
  output logic                          o_ser,
  output logic                          o_busy,
  output logic                          o_done
);

  logic [xcom_link_pkg::FRAME_BITS-1:0] shreg;
  logic [xcom_link_pkg::TMR_W-1:0]      tmr;
  logic [xcom_link_pkg::BCNT_W-1:0]     bcnt;
  logic                                 s_bit_end;

  // last clock of the current bit time
  assign s_bit_end = (tmr == xcom_link_pkg::TMR_LAST);

  ////////////////////////////////////////
  // bit timing
  ////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_busy <= 1'b0;
      o_done <= 1'b0;
      tmr    <= '0;
      bcnt   <= '0;
    end else begin
      o_done <= 1'b0;
      if (i_start) begin
        o_busy <= 1'b1;
        tmr    <= '0;
        bcnt   <= '0;
      end else if (o_busy) begin
        if (s_bit_end) begin
          tmr <= '0;
          // frame ends after the last data bit
          if (bcnt == xcom_link_pkg::BCNT_LAST) begin
            o_busy <= 1'b0;
            o_done <= 1'b1;
          end else begin
            bcnt <= bcnt + 1'b1;
          end
        end else begin
          tmr <= tmr + 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // shifter
  ////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      shreg <= {xcom_link_pkg::START_BIT, i_op, i_data};
    end else if (o_busy && s_bit_end) begin
      shreg <= {shreg[xcom_link_pkg::FRAME_BITS-2:0], xcom_link_pkg::LINE_IDLE};
    end
  end

  // line idles high between frames
  assign o_ser = o_busy ? shreg[xcom_link_pkg::FRAME_BITS-1] : xcom_link_pkg::LINE_IDLE;

  // the collector must wait for done before restarting a lane
  a_no_restart : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_start |-> !o_busy);

endmodule

// File: hdl/xcom_net_ack.sv
// network command collector, starts the addressed lanes and acknowledges once all report done
`timescale 1ns/1ps

module xcom_net_ack (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  input  logic                          i_req,
  input  logic [xcom_pkg::OP_W-1:0]     i_op,
  input  logic [xcom_pkg::ADDR_W-1:0]   i_addr,
  input  logic [xcom_pkg::DATA_W-1:0]   i_data,
  input  logic [xcom_pkg::N_CH-1:0]     i_lane_done,
  output logic [xcom_pkg::N_CH-1:0]     o_lane_start,
  output logic [xcom_pkg::OPF_W-1:0]    o_lane_op,
  output logic [xcom_pkg::DATA_W-1:0]   o_lane_data,
  output logic                          o_ack,
  output logic [xcom_pkg::CNT_W-1:0]    o_frame_cntr
);

  logic [xcom_pkg::N_CH-1:0] s_mask;
  logic [xcom_pkg::N_CH-1:0] s_pend_nxt;
  logic [xcom_pkg::N_CH-1:0] pend;
  logic                      active;
  logic                      s_new;
  logic                      s_launch;

  // lane mask from the address
  // anything that is neither a lane nor broadcast selects nothing
  always_comb begin
    s_mask = '0;
    if (i_addr == xcom_pkg::ADDR_BCAST) begin
      s_mask = '1;
    end else begin
      for (int k = 0; k < xcom_pkg::N_CH; k++) begin
        if (int'(i_addr) == k) begin
          s_mask[k] = 1'b1;
        end
      end
    end
  end

  // fresh request, ignored while its ack is out
  assign s_new      = i_req & ~o_ack & ~active;
  assign s_launch   = s_new & (|s_mask);
  assign s_pend_nxt = pend & ~i_lane_done;

  ////////////////////////////////////////
  // lane launch and done tracking
  ////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      active       <= 1'b0;
      pend         <= '0;
      o_lane_start <= '0;
      o_ack        <= 1'b0;
      o_frame_cntr <= '0;
    end else begin
      o_lane_start <= '0;
      o_ack        <= 1'b0;
      if (s_launch) begin
        active       <= 1'b1;
        pend         <= s_mask;
        o_lane_start <= s_mask;
      end else if (s_new) begin
        // no lane addressed so answer right away
        o_ack        <= 1'b1;
        o_frame_cntr <= o_frame_cntr + 1'b1;
      end else if (active) begin
        pend <= s_pend_nxt;
        if (s_pend_nxt == '0) begin
          active       <= 1'b0;
          o_ack        <= 1'b1;
          o_frame_cntr <= o_frame_cntr + 1'b1;
        end
      end
    end
  end

  // frame content shared by all lanes
  always_ff @(posedge i_clk) begin
    if (s_launch) begin
      o_lane_op   <= {i_op[xcom_pkg::OP_NET_BIT-1:0], i_addr};
      o_lane_data <= i_data;
    end
  end

  // a lane only finishes a frame this collector started
  a_done_pending : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (|i_lane_done) |-> active && ((i_lane_done & ~pend) == '0));

endmodule

// File: hdl/xcom_top.sv
// xcom command front end top, wires the command entry, local executor, lanes and collector
`timescale 1ns/1ps

module xcom_top (
  input  logic                                 i_clk,
  input  logic                                 i_rst_n,
  // sequencer core command
  input  logic                                 i_core_en,
  input  logic [xcom_pkg::OP_W-1:0]            i_core_op,
  input  logic [1:0][xcom_pkg::DATA_W-1:0]     i_core_data,
  // host command
  input  logic [xcom_pkg::PS_CTRL_W-1:0]       i_ps_ctrl,
  input  logic [1:0][xcom_pkg::DATA_W-1:0]     i_ps_data,
  // register file read
  input  logic [xcom_pkg::ADDR_W-1:0]          i_rd_addr,
  output logic [xcom_pkg::N_CH-1:0]            o_ser,
  output logic                                 o_flag,
  output logic [xcom_pkg::DATA_W-1:0]          o_rd_data,
  output logic                                 o_req_loc,
  output logic                                 o_req_net,
  output logic [xcom_pkg::CNT_W-1:0]           o_data_cntr,
  output logic [xcom_pkg::CNT_W-1:0]           o_frame_cntr
);

  logic                          ack_loc;
  logic                          ack_net;
  logic [xcom_pkg::OP_W-1:0]     cmd_op;
  logic [xcom_pkg::ADDR_W-1:0]   cmd_addr;
  logic [xcom_pkg::DATA_W-1:0]   cmd_data;
  logic [xcom_pkg::N_CH-1:0]     lane_start;
  logic [xcom_pkg::N_CH-1:0]     lane_done;
  logic [xcom_pkg::OPF_W-1:0]    lane_op;
  logic [xcom_pkg::DATA_W-1:0]   lane_data;

  xcom_cmd u_cmd (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_core_en   (i_core_en),
    .i_core_op   (i_core_op),
    .i_core_data (i_core_data),
    .i_ps_ctrl   (i_ps_ctrl),
    .i_ps_data   (i_ps_data),
    .i_ack_loc   (ack_loc),
    .i_ack_net   (ack_net),
    .o_req_loc   (o_req_loc),
    .o_req_net   (o_req_net),
    .o_op        (cmd_op),
    .o_addr      (cmd_addr),
    .o_data      (cmd_data),
    .o_data_cntr (o_data_cntr)
  );

  xcom_loc_exec u_loc_exec (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_req     (o_req_loc),
    .i_op      (cmd_op),
    .i_addr    (cmd_addr),
    .i_data    (cmd_data),
    .i_rd_addr (i_rd_addr),
    .o_ack     (ack_loc),
    .o_flag    (o_flag),
    .o_rd_data (o_rd_data)
  );

  xcom_net_ack u_net_ack (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_req        (o_req_net),
    .i_op         (cmd_op),
    .i_addr       (cmd_addr),
    .i_data       (cmd_data),
    .i_lane_done  (lane_done),
    .o_lane_start (lane_start),
    .o_lane_op    (lane_op),
    .o_lane_data  (lane_data),
    .o_ack        (ack_net),
    .o_frame_cntr (o_frame_cntr)
  );

  ////////////////////////////////////////
  // serial lanes
  ////////////////////////////////////////

  // busy stays inside each lane
  for (genvar g = 0; g < xcom_pkg::N_CH; g++) begin : g_lane
    xcom_lane_tx u_lane_tx (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_start (lane_start[g]),
      .i_op    (lane_op),
      .i_data  (lane_data),
      .o_ser   (o_ser[g]),
      .o_busy  (),
      .o_done  (lane_done[g])
    );
  end

endmodule

// File: testbench/tb_xcom_top.sv
// testbench of xcom_top, drives core and host commands and checks registers, flag, frames and counters
`timescale 1ns/1ps

// serial receiver model for one lane, samples each bit in its middle
module serial_frame_rx (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  input  logic                          i_ser,
  output logic                          o_start_bit,
  output logic [xcom_pkg::OPF_W-1:0]    o_op,
  output logic [xcom_pkg::DATA_W-1:0]   o_data,
  output logic [7:0]                    o_frames
);

  logic [xcom_link_pkg::FRAME_BITS-1:0] shift;
  logic                                 busy;
  int                                   tmr;
  int                                   nbit;

  always @(posedge i_clk) begin
    if (!i_rst_n) begin
      busy        <= 1'b0;
      tmr         <= 0;
      nbit        <= 0;
      shift       <= '0;
      o_start_bit <= xcom_link_pkg::LINE_IDLE;
      o_op        <= '0;
      o_data      <= '0;
      o_frames    <= '0;
    end else if (!busy) begin
      // first low sample is clock 0 of the start bit
      if (i_ser != xcom_link_pkg::LINE_IDLE) begin
        busy <= 1'b1;
        tmr  <= 1;
        nbit <= 0;
      end
    end else begin
      if (tmr == xcom_link_pkg::BIT_CLKS / 2) begin
        shift <= {shift[xcom_link_pkg::FRAME_BITS-2:0], i_ser};
        nbit  <= nbit + 1;
      end
      if (tmr == xcom_link_pkg::BIT_CLKS - 1) begin
        tmr <= 0;
        // frame closes on the last clock of the last bit
        if (nbit == xcom_link_pkg::FRAME_BITS) begin
          busy        <= 1'b0;
          o_start_bit <= shift[xcom_link_pkg::FRAME_BITS-1];
          o_op        <= shift[xcom_pkg::DATA_W +: xcom_pkg::OPF_W];
          o_data      <= shift[xcom_pkg::DATA_W-1:0];
          o_frames    <= o_frames + 1'b1;
        end
      end else begin
        tmr <= tmr + 1;
      end
    end
  end

endmodule

module tb_xcom_top;

  logic                                 clk;
  logic                                 rst_n;
  logic                                 core_en;
  logic [xcom_pkg::OP_W-1:0]            core_op;
  logic [1:0][xcom_pkg::DATA_W-1:0]     core_data;
  logic [xcom_pkg::PS_CTRL_W-1:0]       ps_ctrl;
  logic [1:0][xcom_pkg::DATA_W-1:0]     ps_data;
  logic [xcom_pkg::ADDR_W-1:0]          rd_addr;
  logic [xcom_pkg::N_CH-1:0]            ser;
  logic                                 flag;
  logic [xcom_pkg::DATA_W-1:0]          rd_data;
  logic                                 req_loc;
  logic                                 req_net;
  logic [xcom_pkg::CNT_W-1:0]           data_cntr;
  logic [xcom_pkg::CNT_W-1:0]           frame_cntr;

  // receiver outputs per lane
  logic                                 rx_start [xcom_pkg::N_CH];
  logic [xcom_pkg::OPF_W-1:0]           rx_op [xcom_pkg::N_CH];
  logic [xcom_pkg::DATA_W-1:0]          rx_data [xcom_pkg::N_CH];
  logic [7:0]                           rx_frames [xcom_pkg::N_CH];

  // expected state
  logic [xcom_pkg::DATA_W-1:0]          reg_model [2**xcom_pkg::ADDR_W];
  logic                                 exp_flag;
  logic [xcom_pkg::CNT_W-1:0]           exp_data_cntr;
  logic [xcom_pkg::CNT_W-1:0]           exp_frame_cntr;
  logic [7:0]                           exp_frames [xcom_pkg::N_CH];
  logic [xcom_pkg::OPF_W-1:0]           exp_lane_op [xcom_pkg::N_CH];
  logic [xcom_pkg::DATA_W-1:0]          exp_lane_data [xcom_pkg::N_CH];
  // lanes that must stay idle
  logic [xcom_pkg::N_CH-1:0]            quiet_mask;
  logic                                 chk_done;
  int                                   seed;

  always #50 clk = ~clk;

  xcom_top DUT (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .i_core_en    (core_en),
    .i_core_op    (core_op),
    .i_core_data  (core_data),
    .i_ps_ctrl    (ps_ctrl),
    .i_ps_data    (ps_data),
    .i_rd_addr    (rd_addr),
    .o_ser        (ser),
    .o_flag       (flag),
    .o_rd_data    (rd_data),
    .o_req_loc    (req_loc),
    .o_req_net    (req_net),
    .o_data_cntr  (data_cntr),
    .o_frame_cntr (frame_cntr)
  );

  ////////////////////////////////////////
  // failure reporting
  ////////////////////////////////////////

  task automatic value_error(input string name, input logic [63:0] got, input logic [63:0] exp);
    $display("error: %s is 0x%0h, expected 0x%0h", name, got, exp);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timed out waiting for %s", what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  a_ser_idle : assert property (@(posedge clk) disable iff (!rst_n)
    (ser & quiet_mask) == quiet_mask)
    else value_error("o_ser", 64'(ser), 64'(ser | quiet_mask));

  a_req_loc : assert property (@(posedge clk) disable iff (!rst_n) chk_done |-> !req_loc)
    else value_error("o_req_loc", 64'(req_loc), 64'(0));
  a_req_net : assert property (@(posedge clk) disable iff (!rst_n) chk_done |-> !req_net)
    else value_error("o_req_net", 64'(req_net), 64'(0));

  a_data_cntr : assert property (@(posedge clk) disable iff (!rst_n)
    chk_done |-> data_cntr == exp_data_cntr)
    else value_error("o_data_cntr", 64'(data_cntr), 64'(exp_data_cntr));
  a_frame_cntr : assert property (@(posedge clk) disable iff (!rst_n)
    chk_done |-> frame_cntr == exp_frame_cntr)
    else value_error("o_frame_cntr", 64'(frame_cntr), 64'(exp_frame_cntr));

  a_flag : assert property (@(posedge clk) disable iff (!rst_n) chk_done |-> flag == exp_flag)
    else value_error("o_flag", 64'(flag), 64'(exp_flag));
  a_rd_data : assert property (@(posedge clk) disable iff (!rst_n)
    chk_done |-> rd_data == reg_model[rd_addr])
    else value_error("o_rd_data", 64'(rd_data), 64'(reg_model[rd_addr]));

  for (genvar g = 0; g < xcom_pkg::N_CH; g++) begin : g_rx
    serial_frame_rx u_rx (
      .i_clk       (clk),
      .i_rst_n     (rst_n),
      .i_ser       (ser[g]),
      .o_start_bit (rx_start[g]),
      .o_op        (rx_op[g]),
      .o_data      (rx_data[g]),
      .o_frames    (rx_frames[g])
    );

    // every addressed frame is complete before the request drops
    a_frames_at_ack : assert property (@(posedge clk) disable iff (!rst_n)
      $fell(req_net) |-> rx_frames[g] == exp_frames[g])
      else value_error($sformatf("o_ser[%0d] frame count", g),
                       64'(rx_frames[g]), 64'(exp_frames[g]));

    a_frame_start : assert property (@(posedge clk) disable iff (!rst_n)
      chk_done && exp_frames[g] != 0 |-> rx_start[g] == xcom_link_pkg::START_BIT)
      else value_error($sformatf("o_ser[%0d] start bit", g), 64'(rx_start[g]), 64'(0));
    a_frame_op : assert property (@(posedge clk) disable iff (!rst_n)
      chk_done && exp_frames[g] != 0 |-> rx_op[g] == exp_lane_op[g])
      else value_error($sformatf("o_ser[%0d] op field", g),
                       64'(rx_op[g]), 64'(exp_lane_op[g]));
    a_frame_data : assert property (@(posedge clk) disable iff (!rst_n)
      chk_done && exp_frames[g] != 0 |-> rx_data[g] == exp_lane_data[g])
      else value_error($sformatf("o_ser[%0d] data", g),
                       64'(rx_data[g]), 64'(exp_lane_data[g]));
  end

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  // one lane, all lanes for broadcast, none otherwise
  function automatic logic [xcom_pkg::N_CH-1:0] lane_mask(input logic [xcom_pkg::ADDR_W-1:0] addr);
    logic [xcom_pkg::N_CH-1:0] mask;
    mask = '0;
    if (addr == xcom_pkg::ADDR_BCAST) begin
      mask = '1;
    end else if (int'(addr) < xcom_pkg::N_CH) begin
      mask[0] = 1'b1;
      mask = mask << addr;
    end
    return mask;
  endfunction

  task automatic predict_cmd(input logic [xcom_pkg::OP_W-1:0] op,
                             input logic [xcom_pkg::ADDR_W-1:0] addr,
                             input logic [xcom_pkg::DATA_W-1:0] data);
    logic [xcom_pkg::N_CH-1:0] mask;
    mask = lane_mask(addr);
    exp_data_cntr = exp_data_cntr + 1'b1;
    if (op[xcom_pkg::OP_NET_BIT]) begin
      exp_frame_cntr = exp_frame_cntr + 1'b1;
      quiet_mask = ~mask;
      for (int k = 0; k < xcom_pkg::N_CH; k++) begin
        if (mask[k]) begin
          exp_frames[k]    = exp_frames[k] + 1'b1;
          // low opcode nibble over the address nibble
          exp_lane_op[k]   = {op[3:0], addr};
          exp_lane_data[k] = data;
        end
      end
    end else begin
      quiet_mask = '1;
      if (op == xcom_pkg::OP_LOC_WREG) begin
        reg_model[addr] = data;
      end else if (op == xcom_pkg::OP_LOC_FLAG) begin
        exp_flag = data[0];
      end
    end
  endtask

  // idle sources hold zeros
  task automatic clear_sources();
    core_en   = 1'b0;
    core_op   = '0;
    core_data = '0;
    ps_ctrl   = '0;
    ps_data   = '0;
  endtask

  task automatic wait_req_rise();
    int n;
    n = 0;
    while (!(req_loc || req_net) && n < 8) begin
      @(negedge clk);
      n++;
    end
    if (!(req_loc || req_net)) stop_on_timeout("a request to rise");
  endtask

  task automatic wait_req_fall();
    int n;
    n = 0;
    while ((req_loc || req_net) && n < xcom_link_pkg::FRAME_BITS * xcom_link_pkg::BIT_CLKS + 32) begin
      @(negedge clk);
      n++;
    end
    if (req_loc || req_net) stop_on_timeout("the request to fall");
  endtask

  // raise one enable, then release once the request is up
  task automatic drive_cmd(input bit from_host,
                           input logic [xcom_pkg::OP_W-1:0] op,
                           input logic [xcom_pkg::ADDR_W-1:0] addr,
                           input logic [xcom_pkg::DATA_W-1:0] data);
    @(negedge clk);
    if (from_host) begin
      ps_ctrl = {op, 1'b1};
      ps_data[0][xcom_pkg::ADDR_W-1:0] = addr;
      ps_data[1] = data;
    end else begin
      core_en = 1'b1;
      core_op = op;
      core_data[0][xcom_pkg::ADDR_W-1:0] = addr;
      core_data[1] = data;
    end
    wait_req_rise();
    clear_sources();
  endtask

  task automatic hold_check(input int cycles);
    @(negedge clk);
    chk_done = 1'b1;
    repeat (cycles) @(negedge clk);
    chk_done = 1'b0;
  endtask

  task automatic run_cmd(input bit from_host,
                         input logic [xcom_pkg::OP_W-1:0] op,
                         input logic [xcom_pkg::ADDR_W-1:0] addr,
                         input logic [xcom_pkg::DATA_W-1:0] data);
    predict_cmd(op, addr, data);
    drive_cmd(from_host, op, addr, data);
    wait_req_fall();
    hold_check(2);
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    logic [xcom_pkg::DATA_W-1:0] data;
    seed = 30344;
    clk = 1'b0;
    rst_n = 1'b0;
    rd_addr = '0;
    chk_done = 1'b0;
    clear_sources();
    exp_flag = 1'b0;
    exp_data_cntr = '0;
    exp_frame_cntr = '0;
    quiet_mask = '1;
    for (int a = 0; a < 2**xcom_pkg::ADDR_W; a++) begin
      reg_model[a] = '0;
    end
    for (int k = 0; k < xcom_pkg::N_CH; k++) begin
      exp_frames[k] = '0;
      exp_lane_op[k] = '0;
      exp_lane_data[k] = '0;
    end
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    // idle lines, low requests, zero counters after reset
    hold_check(2);

    // register writes from both sources, then read back every entry
    data = $random(seed);
    run_cmd(1'b1, xcom_pkg::OP_LOC_WREG, 4'h3, data);
    data = $random(seed);
    run_cmd(1'b0, xcom_pkg::OP_LOC_WREG, 4'hA, data);
    for (int a = 0; a < 2**xcom_pkg::ADDR_W; a++) begin
      rd_addr = a[xcom_pkg::ADDR_W-1:0];
      hold_check(1);
    end
    rd_addr = 4'h3;

    // flag follows data bit 0, both ways
    data = $random(seed);
    run_cmd(1'b0, xcom_pkg::OP_LOC_FLAG, 4'h0, data);
    run_cmd(1'b0, xcom_pkg::OP_LOC_FLAG, 4'h0, data ^ 32'h1);
    // unknown local opcode only counts
    data = $random(seed);
    run_cmd(1'b1, 5'b0_0111, 4'h3, data);

    // one frame per lane, the other lane stays idle
    for (int k = 0; k < xcom_pkg::N_CH; k++) begin
      data = $random(seed);
      run_cmd(k[0], xcom_pkg::OP_NET_SEND, k[xcom_pkg::ADDR_W-1:0], data);
    end

    // broadcast on every lane
    data = $random(seed);
    run_cmd(1'b1, xcom_pkg::OP_NET_SEND, xcom_pkg::ADDR_BCAST, data);

    // second edge during a busy request is dropped
    data = $random(seed);
    predict_cmd(xcom_pkg::OP_NET_SEND, 4'h0, data);
    drive_cmd(1'b0, xcom_pkg::OP_NET_SEND, 4'h0, data);
    repeat (4) @(negedge clk);
    core_en = 1'b1;
    core_op = xcom_pkg::OP_NET_SEND;
    core_data[0][xcom_pkg::ADDR_W-1:0] = 4'h1;
    core_data[1] = $random(seed);
    repeat (2) @(negedge clk);
    clear_sources();
    wait_req_fall();
    // no late request and no frame on lane 1
    hold_check(16);

    // address that is neither a lane nor broadcast
    data = $random(seed);
    run_cmd(1'b1, xcom_pkg::OP_NET_SEND, 4'h5, data);
    hold_check(8);

    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: verilog.f
hdl/xcom_pkg.sv
hdl/xcom_link_pkg.sv
hdl/xcom_cmd.sv
hdl/xcom_loc_exec.sv
hdl/xcom_lane_tx.sv
hdl/xcom_net_ack.sv
hdl/xcom_top.sv
testbench/tb_xcom_top.sv

// File: Makefile
# Verilator build and run of the xcom front end testbench

SIM      = verilator
TOP      = tb_xcom_top
FILELIST = verilog.f
FLAGS    = --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir
